//--- dv/motor_regs_stim.txt
# columns: op name addr_or_motor data expected (hex); W write, R read, I idle
# D/S drive/rot status, A angle, N done, C/O drive/rot ctrl, T target, P cmd, Z reset
Z reset_outputs 00 00 00
R reset_rd_drv0 04 00 00
R reset_unmapped 3F 00 00
W drv1_write 06 A5 00
C drv1_ctrl 01 00 A5
C drv0_unchanged 00 00 00
R drv1_readback 06 00 A5
W bcast_drive 03 3C 00
C bcast_drv3 03 00 3C
O bcast_drv_rot0 00 00 00
W bcast_rot 02 C7 00
O bcast_rot2 02 00 C7
C bcast_rot_drv2 02 00 3C
W bcast_all 01 6B 00
C bcast_all_drv0 00 00 6B
O bcast_all_rot1 01 00 6B
W rot2_ctrl 16 49 00
W rot2_target 18 D2 00
T rot2_target 02 00 9D2
D drv2_status 02 A7 00
S rot3_status 03 5E 00
A rot3_angle 03 ABC 00
N done_set 00 08 00
I settle 00 00 00
R drv2_status_rd 09 00 A7
R rot3_status_rd 1C 00 5E
W rot3_snap 1F 40 00
A rot3_angle_new 03 123 00
R rot3_ang_lo 1E 00 BC
R rot3_ang_hi 1F 00 8A
W rot0_update 10 20 00
P rot0_update_hi 00 00 2
P rot1_quiet 01 00 0
I wait_upd 00 00 00
P rot0_update_lo 00 00 0
W rot1_abort 15 10 00
P rot1_abort_hi 01 00 1
I wait_abt 00 00 00
P rot1_abort_lo 01 00 0

//--- motor_regs.f
+incdir+verilog
verilog/motor_regs_pkg.sv
verilog/reg_addr_decode.sv
verilog/drive_motor_regs.sv
verilog/rotation_motor_regs.sv
verilog/reg_read_mux.sv
verilog/motor_regs.sv
dv/motor_regs_asserts.sv
dv/motor_regs_tb.sv

//--- dv/motor_regs_tb.sv
//**********************************************************************
// Testbench for motor_regs, replays dv/motor_regs_stim.txt from the root
// One bus operation per clock, inputs driven 10 ns after the rising edge
//**********************************************************************
`timescale 1ns/100ps
`include "motor_regs_macros.svh"

module motor_regs_tb;

    import motor_regs_pkg::*;

    logic                                   clock;
    logic                                   rst_n;
    reg_bus_t                               bus;
    logic          [`MR_DATA_W-1:0]         rd_data;
    motor_status_t [`MR_NUM_DRIVE-1:0]      drive_status;
    motor_status_t [`MR_NUM_ROT-1:0]        rot_status;
    angle_t        [`MR_NUM_ROT-1:0]        current_angle;
    logic          [`MR_NUM_ROT-1:0]        angle_done;
    drive_ctrl_t   [`MR_NUM_DRIVE-1:0]      drive_ctrl;
    rot_ctrl_t     [`MR_NUM_ROT-1:0]        rot_ctrl;
    angle_t        [`MR_NUM_ROT-1:0]        target_angle;
    rot_cmd_t      [`MR_NUM_ROT-1:0]        rot_cmd;

    // Parsed stimulus, one entry per operation
    string       op_q[$];
    string       name_q[$];
    logic [31:0] arg_q[$];   // Address or motor index
    logic [31:0] data_q[$];
    logic [31:0] exp_q[$];

    int cycles = 0;
    int cycle_limit = 1000;  // Replaced once the file is read

    motor_regs dut0 (
        .clock         (clock),
        .rst_n         (rst_n),
        .bus           (bus),
        .rd_data       (rd_data),
        .drive_status  (drive_status),
        .rot_status    (rot_status),
        .current_angle (current_angle),
        .angle_done    (angle_done),
        .drive_ctrl    (drive_ctrl),
        .rot_ctrl      (rot_ctrl),
        .target_angle  (target_angle),
        .rot_cmd       (rot_cmd)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;  // 100 ns period
    end

    task automatic end_with_failure(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped on first error");
    endtask

    task automatic next_cycle();
        @(posedge clock);
        #10;                         // Drive point after the edge
    endtask

    task automatic check_byte(input string name, input logic [`MR_DATA_W-1:0] exp,
                              input logic [`MR_DATA_W-1:0] act);
        if (act !== exp) begin
            end_with_failure($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_drive_ctrl(input string name, input drive_ctrl_t exp,
                                    input drive_ctrl_t act);
        if (act !== exp) begin
            end_with_failure($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_rot_ctrl(input string name, input rot_ctrl_t exp, input rot_ctrl_t act);
        if (act !== exp) begin
            end_with_failure($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_angle(input string name, input angle_t exp, input angle_t act);
        if (act !== exp) begin
            end_with_failure($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_cmd(input string name, input rot_cmd_t exp, input rot_cmd_t act);
        if (act !== exp) begin
            end_with_failure($sformatf("Mismatch %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    // Everything the DUT drives must be clear after reset
    task automatic check_all_zero(input string name);
        check_byte(name, '0, rd_data);
        for (int i = 0; i < `MR_NUM_DRIVE; i++) begin
            check_drive_ctrl(name, '0, drive_ctrl[i]);
        end
        for (int i = 0; i < `MR_NUM_ROT; i++) begin
            check_rot_ctrl(name, '0, rot_ctrl[i]);
            check_angle(name, '0, target_angle[i]);
            check_cmd(name, '0, rot_cmd[i]);
        end
    endtask

    task automatic bus_write(input logic [`MR_ADDR_W-1:0] addr, input logic [`MR_DATA_W-1:0] data);
        bus.address  = addr;
        bus.wr_data  = data;
        bus.write_en = 1'b1;
        next_cycle();                // Write edge
        bus.write_en = 1'b0;
    endtask

    task automatic bus_read_check(input string name, input logic [`MR_ADDR_W-1:0] addr,
                                  input logic [`MR_DATA_W-1:0] exp);
        bus.address = addr;
        bus.read_en = 1'b1;
        next_cycle();                // rd_data loaded here
        bus.read_en = 1'b0;
        check_byte(name, exp, rd_data);
    endtask

    task automatic run_op(input string op, input string name, input logic [31:0] arg,
                          input logic [31:0] data, input logic [31:0] exp);
        logic [1:0] idx;
        idx = arg[1:0];
        case (op)
            "W": bus_write(arg[`MR_ADDR_W-1:0], data[`MR_DATA_W-1:0]);
            "R": bus_read_check(name, arg[`MR_ADDR_W-1:0], exp[`MR_DATA_W-1:0]);
            "D": drive_status[idx] = data[`MR_DATA_W-1:0];
            "S": rot_status[idx] = data[`MR_DATA_W-1:0];
            "A": current_angle[idx] = data[`MR_ANGLE_W-1:0];
            "N": angle_done = data[`MR_NUM_ROT-1:0];
            "I": next_cycle();
            "C": check_drive_ctrl(name, drive_ctrl_t'(exp[7:0]), drive_ctrl[idx]);
            "O": check_rot_ctrl(name, rot_ctrl_t'(exp[7:0]), rot_ctrl[idx]);
            "T": check_angle(name, angle_t'(exp[`MR_ANGLE_W-1:0]), target_angle[idx]);
            "P": check_cmd(name, rot_cmd_t'(exp[1:0]), rot_cmd[idx]);
            "Z": check_all_zero(name);
            default: end_with_failure($sformatf("Unknown operation %s in line %s", op, name));
        endcase
    endtask

    // Timeout and assertion watch
    always @(posedge clock) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            end_with_failure($sformatf("Run did not finish within %0d cycles", cycle_limit));
        end
        if (dut0.u_asserts.assert_errors != 0) begin
            end_with_failure("A bus timing assertion failed");
        end
    end

    initial begin
        int    fd;
        int    n;
        string line;
        string op;
        string name;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] e;
        rst_n         = 1'b0;
        bus           = '0;
        drive_status  = '0;
        rot_status    = '0;
        current_angle = '0;
        angle_done    = '0;
        fd = $fopen("dv/motor_regs_stim.txt", "r");
        if (fd == 0) begin
            end_with_failure("Cannot open the stimulus file dv/motor_regs_stim.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line[0] != "#") begin   // Skip comments, blanks
                n = $sscanf(line, "%s %s %h %h %h", op, name, a, d, e);
                if (n == 5) begin
                    op_q.push_back(op);
                    name_q.push_back(name);
                    arg_q.push_back(a);
                    data_q.push_back(d);
                    exp_q.push_back(e);
                end
            end
        end
        $fclose(fd);
        cycle_limit = 10 + 4 * op_q.size() + 50;
        repeat (10) next_cycle();    // Reset held for 10 cycles
        rst_n = 1'b1;
        foreach (op_q[k]) begin
            run_op(op_q[k], name_q[k], arg_q[k], data_q[k], exp_q[k]);
        end
        repeat (2) next_cycle();     // Let the last assertions settle
        if (dut0.u_asserts.assert_errors != 0) begin
            end_with_failure("A bus timing assertion failed");
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

//--- dv/motor_regs_asserts.sv
//**********************************************************************
// Bound checks on command pulse shape and rd_data hold
// Assumes no back-to-back command writes to the same motor
//**********************************************************************
`timescale 1ns/100ps
`include "motor_regs_macros.svh"

module motor_regs_asserts (
    input logic                                       clock,
    input logic                                       rst_n,
    input motor_regs_pkg::reg_bus_t                   bus,
    input logic                     [`MR_DATA_W-1:0]  rd_data,
    input motor_regs_pkg::rot_cmd_t [`MR_NUM_ROT-1:0] rot_cmd
);

    int assert_errors = 0;  // Polled by the testbench

    // Pulse follows a write edge and lasts one cycle
    property p_pulse(cmd_bit);
        @(posedge clock) disable iff (!rst_n)
        cmd_bit |-> $past(bus.write_en) ##1 !cmd_bit;
    endproperty

    for (genvar i = 0; i < `MR_NUM_ROT; i++) begin : g_cmd
        a_update: assert property (p_pulse(rot_cmd[i].update))
            else begin
                assert_errors++;
                $error("rot_cmd update pulse malformed on motor %0d", i);
            end
        a_abort: assert property (p_pulse(rot_cmd[i].abort))
            else begin
                assert_errors++;
                $error("rot_cmd abort pulse malformed on motor %0d", i);
            end
    end

    a_rd_hold: assert property (@(posedge clock) disable iff (!rst_n)
                                !bus.read_en |=> $stable(rd_data))
        else begin
            assert_errors++;
            $error("rd_data changed without a read request");
        end

endmodule

bind motor_regs motor_regs_asserts u_asserts (
    .clock   (clock),
    .rst_n   (rst_n),
    .bus     (bus),
    .rd_data (rd_data),
    .rot_cmd (rot_cmd)
);

//--- verilog/motor_regs.sv
//**********************************************************************
// Motor board register file top, host bus to drive and swerve motors
// Single-cycle writes, reads return data one clock after read_en
//**********************************************************************
`timescale 1ns/100ps
`include "motor_regs_macros.svh"

module motor_regs (
    input  logic                                              clock,
    input  logic                                              rst_n,
    input  motor_regs_pkg::reg_bus_t                          bus,
    output logic                          [`MR_DATA_W-1:0]    rd_data,
    input  motor_regs_pkg::motor_status_t [`MR_NUM_DRIVE-1:0] drive_status,
    input  motor_regs_pkg::motor_status_t [`MR_NUM_ROT-1:0]   rot_status,
    input  motor_regs_pkg::angle_t        [`MR_NUM_ROT-1:0]   current_angle,
    input  logic                          [`MR_NUM_ROT-1:0]   angle_done,
    output motor_regs_pkg::drive_ctrl_t   [`MR_NUM_DRIVE-1:0] drive_ctrl,
    output motor_regs_pkg::rot_ctrl_t     [`MR_NUM_ROT-1:0]   rot_ctrl,
    output motor_regs_pkg::angle_t        [`MR_NUM_ROT-1:0]   target_angle,
    output motor_regs_pkg::rot_cmd_t      [`MR_NUM_ROT-1:0]   rot_cmd
);

    import motor_regs_pkg::*;

    // Write strobes
    logic [`MR_NUM_DRIVE-1:0] drive_ctrl_we;
    logic [`MR_NUM_ROT-1:0]   rot_ctrl_we;
    logic [`MR_NUM_ROT-1:0]   rot_target_we;
    logic [`MR_NUM_ROT-1:0]   rot_cmd_we;

    // Registered read sources
    motor_status_t [`MR_NUM_DRIVE-1:0] drive_status_q;
    motor_status_t [`MR_NUM_ROT-1:0]   rot_status_q;
    angle_t        [`MR_NUM_ROT-1:0]   snap;
    logic          [`MR_NUM_ROT-1:0]   done_q;

    reg_addr_decode u_decode (
        .bus           (bus),
        .drive_ctrl_we (drive_ctrl_we),
        .rot_ctrl_we   (rot_ctrl_we),
        .rot_target_we (rot_target_we),
        .rot_cmd_we    (rot_cmd_we)
    );

    drive_motor_regs u_drive (
        .clock     (clock),
        .rst_n     (rst_n),
        .ctrl_we   (drive_ctrl_we),
        .wr_data   (bus.wr_data),     // Decoded as drive_ctrl_t inside
        .status_in (drive_status),
        .ctrl      (drive_ctrl),
        .status_q  (drive_status_q)
    );

    rotation_motor_regs u_rot (
        .clock         (clock),
        .rst_n         (rst_n),
        .ctrl_we       (rot_ctrl_we),
        .target_we     (rot_target_we),
        .cmd_we        (rot_cmd_we),
        .wr_data       (bus.wr_data), // Same byte, rotation view
        .status_in     (rot_status),
        .current_angle (current_angle),
        .angle_done    (angle_done),
        .ctrl          (rot_ctrl),
        .target_angle  (target_angle),
        .rot_cmd       (rot_cmd),
        .status_q      (rot_status_q),
        .snap          (snap),
        .done_q        (done_q)
    );

    reg_read_mux u_rd_mux (
        .clock        (clock),
        .rst_n        (rst_n),
        .bus          (bus),
        .drive_ctrl   (drive_ctrl),
        .drive_status (drive_status_q),
        .rot_ctrl     (rot_ctrl),
        .rot_target   (target_angle),
        .rot_status   (rot_status_q),
        .snap         (snap),
        .done_q       (done_q),
        .rd_data      (rd_data)
    );

endmodule

//--- verilog/reg_read_mux.sv
//**********************************************************************
// Read decode, rd_data valid one clock after read_en
// Unmapped and broadcast addresses read as zero
//**********************************************************************
`timescale 1ns/100ps
`include "motor_regs_macros.svh"

module reg_read_mux (
    input  logic                                              clock,
    input  logic                                              rst_n,
    input  motor_regs_pkg::reg_bus_t                          bus,
    input  motor_regs_pkg::drive_ctrl_t   [`MR_NUM_DRIVE-1:0] drive_ctrl,
    input  motor_regs_pkg::motor_status_t [`MR_NUM_DRIVE-1:0] drive_status,
    input  motor_regs_pkg::rot_ctrl_t     [`MR_NUM_ROT-1:0]   rot_ctrl,
    input  motor_regs_pkg::angle_t        [`MR_NUM_ROT-1:0]   rot_target,  // Low byte read back
    input  motor_regs_pkg::motor_status_t [`MR_NUM_ROT-1:0]   rot_status,
    input  motor_regs_pkg::angle_t        [`MR_NUM_ROT-1:0]   snap,
    input  logic                          [`MR_NUM_ROT-1:0]   done_q,
    output logic                          [`MR_DATA_W-1:0]    rd_data
);

    logic [`MR_DATA_W-1:0] rd_next;
    logic [`MR_ADDR_W-1:0] blk;       // Current rotation block base

    always_comb begin
        rd_next = '0;
        blk     = '0;
        for (int i = 0; i < `MR_NUM_DRIVE; i++) begin
            if (bus.address == `MR_ADDR_W'(`MR_ADDR_DRIVE_BASE + `MR_DRIVE_STRIDE * i)) begin
                rd_next = drive_ctrl[i];
            end
            if (bus.address == `MR_ADDR_W'(`MR_ADDR_DRIVE_BASE + `MR_DRIVE_STRIDE * i + 1)) begin
                rd_next = drive_status[i];
            end
        end
        for (int i = 0; i < `MR_NUM_ROT; i++) begin
            blk = `MR_ADDR_W'(`MR_ADDR_ROT_BASE + `MR_ROT_STRIDE * i);
            case (bus.address - blk)
                `MR_ADDR_W'(`MR_ROT_OFS_CTRL):   rd_next = rot_ctrl[i];
                `MR_ADDR_W'(`MR_ROT_OFS_STATUS): rd_next = rot_status[i];
                `MR_ADDR_W'(`MR_ROT_OFS_TARGET): rd_next = rot_target[i][`MR_DATA_W-1:0];
                `MR_ADDR_W'(`MR_ROT_OFS_ANG_LO): rd_next = snap[i][`MR_DATA_W-1:0];
                `MR_ADDR_W'(`MR_ROT_OFS_ANG_HI):               // Done, 3 zeros, high nibble
                    rd_next = {done_q[i], 3'b000, snap[i][`MR_ANGLE_W-1:`MR_DATA_W]};
                default: ;                                     // Other block, keep value
            endcase
        end
    end

    // Holds between reads
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            rd_data <= '0;
        end else if (bus.read_en) begin
            rd_data <= rd_next;
        end
    end

endmodule

//--- verilog/rotation_motor_regs.sv
//**********************************************************************
// Swerve rotation registers: control, target, snapshot and commands
// Update and abort are single-cycle pulses, back-to-back writes stretch them
//**********************************************************************
`timescale 1ns/100ps
`include "motor_regs_macros.svh"

module rotation_motor_regs (
    input  logic                                            clock,
    input  logic                                            rst_n,
    input  logic                          [`MR_NUM_ROT-1:0] ctrl_we,
    input  logic                          [`MR_NUM_ROT-1:0] target_we,
    input  logic                          [`MR_NUM_ROT-1:0] cmd_we,     // ANG_HI write
    input  motor_regs_pkg::ctrl_word_u                      wr_data,
    input  motor_regs_pkg::motor_status_t [`MR_NUM_ROT-1:0] status_in,
    input  motor_regs_pkg::angle_t        [`MR_NUM_ROT-1:0] current_angle,
    input  logic                          [`MR_NUM_ROT-1:0] angle_done,
    output motor_regs_pkg::rot_ctrl_t     [`MR_NUM_ROT-1:0] ctrl,
    output motor_regs_pkg::angle_t        [`MR_NUM_ROT-1:0] target_angle,
    output motor_regs_pkg::rot_cmd_t      [`MR_NUM_ROT-1:0] rot_cmd,
    output motor_regs_pkg::motor_status_t [`MR_NUM_ROT-1:0] status_q,
    output motor_regs_pkg::angle_t        [`MR_NUM_ROT-1:0] snap,       // Held for two-byte read
    output logic                          [`MR_NUM_ROT-1:0] done_q
);

    import motor_regs_pkg::*;

    rot_ctrl_t                            wr_ctrl;    // Rotation view of the byte
    logic      [`MR_NUM_ROT-1:0][`MR_DATA_W-1:0] target_lo;  // Target angle low bytes

    assign wr_ctrl = wr_data.rot;

    // Control and target bytes
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            ctrl      <= '0;
            target_lo <= '0;
        end else begin
            for (int i = 0; i < `MR_NUM_ROT; i++) begin
                if (ctrl_we[i]) begin
                    ctrl[i] <= wr_ctrl;
                end
                if (target_we[i]) begin
                    target_lo[i] <= wr_data;  // Whole byte, no field split
                end
            end
        end
    end

    // High nibble lives in the control register
    always_comb begin
        for (int i = 0; i < `MR_NUM_ROT; i++) begin
            target_angle[i] = {ctrl[i].angle_hi, target_lo[i]};
        end
    end

    // Command pulses and snapshot, all from one ANG_HI write
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            rot_cmd <= '0;
            snap    <= '0;
        end else begin
            for (int i = 0; i < `MR_NUM_ROT; i++) begin
                rot_cmd[i].update <= cmd_we[i] & wr_data[`MR_CMD_UPDATE_BIT];
                rot_cmd[i].abort  <= cmd_we[i] & wr_data[`MR_CMD_ABORT_BIT];  // Self-clearing
                // Freeze angle so low and high reads match
                if (cmd_we[i] && wr_data[`MR_CMD_SNAP_BIT]) begin
                    snap[i] <= current_angle[i];
                end
            end
        end
    end

    // Status and done sampled each clock
    always_ff @(posedge clock) begin
        status_q <= status_in;
        done_q   <= angle_done;
    end

endmodule

//--- verilog/drive_motor_regs.sv
//**********************************************************************
// Drive motor control registers and status capture
// Status is sampled every clock, no handshake with the motor side
//**********************************************************************
`timescale 1ns/100ps
`include "motor_regs_macros.svh"

module drive_motor_regs (
    input  logic                                              clock,
    input  logic                                              rst_n,
    input  logic                          [`MR_NUM_DRIVE-1:0] ctrl_we,   // One-hot per motor
    input  motor_regs_pkg::ctrl_word_u                        wr_data,
    input  motor_regs_pkg::motor_status_t [`MR_NUM_DRIVE-1:0] status_in,
    output motor_regs_pkg::drive_ctrl_t   [`MR_NUM_DRIVE-1:0] ctrl,
    output motor_regs_pkg::motor_status_t [`MR_NUM_DRIVE-1:0] status_q
);

    import motor_regs_pkg::*;

    drive_ctrl_t wr_ctrl;  // Drive view of the written byte

    assign wr_ctrl = wr_data.drive;

    // Control registers, motors held off in reset
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            ctrl <= '0;
        end else begin
            for (int i = 0; i < `MR_NUM_DRIVE; i++) begin
                if (ctrl_we[i]) begin
                    ctrl[i] <= wr_ctrl;  // Also taken on broadcast
                end
            end
        end
    end

    // Free-running status sample
    always_ff @(posedge clock) begin
        status_q <= status_in;
    end

endmodule

//--- verilog/reg_addr_decode.sv
//**********************************************************************
// Write strobe decode, purely combinational
// Broadcast addresses hit control registers only, never target or command
//**********************************************************************
`timescale 1ns/100ps
`include "motor_regs_macros.svh"

module reg_addr_decode (
    input  motor_regs_pkg::reg_bus_t bus,
    output logic [`MR_NUM_DRIVE-1:0] drive_ctrl_we,
    output logic [`MR_NUM_ROT-1:0]   rot_ctrl_we,
    output logic [`MR_NUM_ROT-1:0]   rot_target_we,
    output logic [`MR_NUM_ROT-1:0]   rot_cmd_we
);

    logic bcast_drive;   // Write to a drive-wide broadcast
    logic bcast_rot;     // Write to a rotation-wide broadcast

    assign bcast_drive = bus.write_en & ((bus.address == `MR_ADDR_BCAST_ALL) |
                                         (bus.address == `MR_ADDR_BCAST_DRIVE));
    assign bcast_rot   = bus.write_en & ((bus.address == `MR_ADDR_BCAST_ALL) |
                                         (bus.address == `MR_ADDR_BCAST_ROT));

    for (genvar i = 0; i < `MR_NUM_DRIVE; i++) begin : g_drive
        localparam logic [`MR_ADDR_W-1:0] CTRL_ADDR =
            `MR_ADDR_W'(`MR_ADDR_DRIVE_BASE + `MR_DRIVE_STRIDE * i);

        assign drive_ctrl_we[i] = (bus.write_en & (bus.address == CTRL_ADDR)) | bcast_drive;
    end

    for (genvar i = 0; i < `MR_NUM_ROT; i++) begin : g_rot
        // First register of this rotation block
        localparam logic [`MR_ADDR_W-1:0] BLK_ADDR =
            `MR_ADDR_W'(`MR_ADDR_ROT_BASE + `MR_ROT_STRIDE * i);
        localparam logic [`MR_ADDR_W-1:0] CTRL_ADDR = BLK_ADDR + `MR_ADDR_W'(`MR_ROT_OFS_CTRL);
        localparam logic [`MR_ADDR_W-1:0] TGT_ADDR  = BLK_ADDR + `MR_ADDR_W'(`MR_ROT_OFS_TARGET);
        localparam logic [`MR_ADDR_W-1:0] CMD_ADDR  = BLK_ADDR + `MR_ADDR_W'(`MR_ROT_OFS_ANG_HI);

        assign rot_ctrl_we[i]   = (bus.write_en & (bus.address == CTRL_ADDR)) | bcast_rot;
        assign rot_target_we[i] = bus.write_en & (bus.address == TGT_ADDR);
        assign rot_cmd_we[i]    = bus.write_en & (bus.address == CMD_ADDR); // ANG_HI write
    end

endmodule

//--- verilog/motor_regs_pkg.sv
//**********************************************************************
// Bus, control, status and command types of the motor register file
// Control byte layout is shared by drive and rotation motors (bits 7:5)
//**********************************************************************
`include "motor_regs_macros.svh"

package motor_regs_pkg;

    // Host bus, one transfer per clock
    typedef struct packed {
        logic [`MR_ADDR_W-1:0] address;
        logic                  write_en;
        logic [`MR_DATA_W-1:0] wr_data;
        logic                  read_en;
    } reg_bus_t;

    typedef struct packed {
        logic       brake;     // Bit 7
        logic       enable;
        logic       direction;
        logic [4:0] pwm;       // PWM level
    } drive_ctrl_t;

    typedef struct packed {
        logic                             brake;
        logic                             enable;
        logic                             direction;
        logic                             rsvd;      // Unused, stored as written
        logic [`MR_ANGLE_W-`MR_DATA_W-1:0] angle_hi; // Target angle bits 11:8
    } rot_ctrl_t;

    // One control byte, two decodings
    // Broadcast to all motors lands the same byte in both kinds
    typedef union packed {
        drive_ctrl_t drive;
        rot_ctrl_t   rot;
    } ctrl_word_u;

    typedef struct packed {
        logic       fault;
        logic       startup_fail;
        logic [5:0] adc_temp;  // ADC temperature code
    } motor_status_t;

    typedef struct packed {
        logic update;          // Start move to target
        logic abort;           // Stop current move
    } rot_cmd_t;

    typedef logic [`MR_ANGLE_W-1:0] angle_t;

endpackage

//--- verilog/motor_regs_macros.svh
//**********************************************************************
// Register map and widths of the motor board register file
// Addresses are 6-bit; rotation blocks are 5 registers apart
//**********************************************************************
`ifndef MOTOR_REGS_MACROS_SVH
`define MOTOR_REGS_MACROS_SVH

`define MR_DATA_W           8       // Register width
`define MR_ADDR_W           6       // Bus address width
`define MR_ANGLE_W          12      // Swerve angle width

`define MR_NUM_DRIVE        4
`define MR_NUM_ROT          4

// Broadcast write addresses
`define MR_ADDR_BCAST_ALL   6'h01   // All eight control registers
`define MR_ADDR_BCAST_ROT   6'h02   // Rotation control only
`define MR_ADDR_BCAST_DRIVE 6'h03   // Drive control only

`define MR_ADDR_DRIVE_BASE  6'h04   // Drive n control at base + 2n, status above
`define MR_DRIVE_STRIDE     2

`define MR_ADDR_ROT_BASE    6'h0C
`define MR_ROT_STRIDE       5
`define MR_ROT_OFS_CTRL     0
`define MR_ROT_OFS_STATUS   1
`define MR_ROT_OFS_TARGET   2       // Target angle low byte
`define MR_ROT_OFS_ANG_LO   3       // Snapshot low byte
`define MR_ROT_OFS_ANG_HI   4       // Done + snapshot high nibble, command on write

`define MR_CMD_ABORT_BIT    4
`define MR_CMD_UPDATE_BIT   5
`define MR_CMD_SNAP_BIT     6

`endif
